// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -f gbfInterface.f --top-module gbfInterface

sim:
	verilator --binary --timing -f gbfInterface.f --top-module gbfInterfaceTb
	out=$$(./obj_dir/VgbfInterfaceTb); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: gbfInterface.f
+incdir+hdl
hdl/gbfIfPkg.sv
hdl/bufferLevelMonitor.sv
hdl/ifArbiter.sv
hdl/burstController.sv
hdl/gbfInterface.sv
tests/gbfInterfaceTb.sv

// File: hdl/bufferLevelMonitor.sv
// Occupancy tracker for one GBF buffer
// Counter saturates at 0 and DEPTH so stray enables cannot wrap it
// Clear has priority over the enables

`timescale 1ns/1ps

module bufferLevelMonitor #(
    parameter int DEPTH     = 16,
    parameter int WATERMARK = 4,
    // 0 asks for refill when low, 1 asks for drain when high
    parameter bit DRAIN     = 1'b0
) (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic enWr,
    input  logic enRd,
    output logic serviceReq
);

    // One extra bit so a full buffer is distinct from empty
    localparam int OccW = $clog2(DEPTH) + 1;

    logic [OccW-1:0] occupancy;
    logic            isFull;
    logic            isEmpty;

    assign isFull  = (occupancy == OccW'(DEPTH));
    assign isEmpty = (occupancy == '0);

    // ====================
    // Occupancy counter
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else if (clear) begin
            occupancy <= '0;
        end else begin
            case ({enWr, enRd})
                // Write alone
                2'b10: begin
                    if (!isFull) begin
                        occupancy <= occupancy + 1'b1;
                    end
                end
                // Read alone
                2'b01: begin
                    if (!isEmpty) begin
                        occupancy <= occupancy - 1'b1;
                    end
                end
                // Both or neither leave the level alone
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Watermark compare straight off the register
    assign serviceReq = DRAIN ? (occupancy > OccW'(WATERMARK))
                              : (occupancy <= OccW'(WATERMARK));

endmodule

// File: hdl/burstController.sv
// Holds one arbiter grant for a fixed-length burst on the external link
// A beat needs ifReq, ifRdy and ifVal high in the same cycle
// Code and direction are frozen until the last beat

`timescale 1ns/1ps

`include "gbfIf_params.svh"

module burstController
    import gbfIfPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  reqAny,
    input  ifCfgT nextCfg,
    input  logic  nextRdWr,
    input  logic  ifRdy,
    input  logic  ifVal,
    output logic  ifReq,
    output ifCfgT ifCfg,
    output logic  ifRdWr
);

    // Wide enough to hold IF_BURST_LEN itself
    localparam int BeatW = $clog2(`IF_BURST_LEN + 1);

    logic [BeatW-1:0] beatCnt;
    logic             beat;
    logic             lastBeat;

    // Stalls simply hold off the beat
    assign beat     = ifReq && ifRdy && ifVal;
    assign lastBeat = beat && (beatCnt == BeatW'(`IF_BURST_LEN - 1));

    // ====================
    // Burst FSM
    // ====================
    // Two states, idle and burst, with ifReq as the state bit
    always_ff @(posedge clk) begin
        if (reset) begin
            ifReq   <= 1'b0;
            beatCnt <= '0;
        end else if (!ifReq) begin
            // Idle for one cycle at least between grants
            beatCnt <= '0;
            if (reqAny) begin
                ifReq <= 1'b1;
            end
        end else if (lastBeat) begin
            ifReq   <= 1'b0;
            beatCnt <= '0;
        end else if (beat) begin
            beatCnt <= beatCnt + 1'b1;
        end
    end

    // ====================
    // Granted code
    // ====================
    // Latched on grant so a later higher request waits its turn
    always_ff @(posedge clk) begin
        if (reset) begin
            ifCfg  <= Empty;
            ifRdWr <= 1'b1;
        end else if (!ifReq && reqAny) begin
            ifCfg  <= nextCfg;
            ifRdWr <= nextRdWr;
        end else if (lastBeat) begin
            // Back to the idle code
            ifCfg  <= Empty;
            ifRdWr <= 1'b1;
        end
    end

endmodule

// File: hdl/gbfIfPkg.sv
// Shared types for the GBF interface arbiter
// Code values are fixed by the far side of the external link

package gbfIfPkg;

    // ====================
    // Interface codes
    // ====================
    // Carried on ifCfg for the whole burst
    typedef enum logic [3:0] {
        Cfg    = 4'd0,
        Act    = 4'd2,
        FlgAct = 4'd4,
        Wei    = 4'd6,
        FlgWei = 4'd8,
        FlgOfm = 4'd10,
        Ofm    = 4'd11,
        Empty  = 4'd15
    } ifCfgT;

    // ====================
    // Buffer index
    // ====================
    // Bit position of each buffer in the request vector
    typedef enum logic [2:0] {
        BufFlgWei = 3'd0,
        BufWei    = 3'd1,
        BufFlgAct = 3'd2,
        BufAct    = 3'd3,
        BufFlgOfm = 3'd4,
        BufOfm    = 3'd5
    } bufIdxT;

    // Number of monitored buffers
    localparam int NumBuf = 6;

endpackage

// File: hdl/gbfIf_params.svh
// Sizes for the GBF off-chip interface arbiter
// Depths are powers of two taken from the address widths
// Watermarks are fractions of depth and must divide evenly
`ifndef GBF_IF_PARAMS_SVH
`define GBF_IF_PARAMS_SVH

// ====================
// Buffer address widths
// ====================
// Flag buffers of depth 16
`define GBF_FLGWEI_AW 4
`define GBF_FLGACT_AW 4
`define GBF_FLGOFM_AW 4

// Data buffers of depth 64
`define GBF_WEI_AW 6
`define GBF_ACT_AW 6
`define GBF_OFM_AW 6

// ====================
// Watermarks
// ====================
// Fill buffers ask for refill at or below 1/4 full
`define GBF_LOW_NUM 1
`define GBF_LOW_DEN 4

// Drain buffers ask to be emptied above 3/4 full
`define GBF_HIGH_NUM 3
`define GBF_HIGH_DEN 4

// Beats per external burst
`define IF_BURST_LEN 4

`endif

// File: hdl/gbfInterface.sv
// Top of the GBF off-chip interface arbiter
// Buffer enables and clears come from the GBF control logic
// ifRdWr high means DRAM to buffer

`timescale 1ns/1ps

module gbfInterface
    import gbfIfPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clearWei,
    input  logic  clearAct,
    input  logic  clearOfm,
    input  logic  cfgReq,
    input  logic  gbfFlgWeiEnWr,
    input  logic  gbfFlgWeiEnRd,
    input  logic  gbfWeiEnWr,
    input  logic  gbfWeiEnRd,
    input  logic  gbfFlgActEnWr,
    input  logic  gbfFlgActEnRd,
    input  logic  gbfActEnWr,
    input  logic  gbfActEnRd,
    input  logic  gbfFlgOfmEnWr,
    input  logic  gbfFlgOfmEnRd,
    input  logic  gbfOfmEnWr,
    input  logic  gbfOfmEnRd,
    input  logic  ifRdy,
    input  logic  ifVal,
    output logic  ifReq,
    output ifCfgT ifCfg,
    output logic  ifRdWr
);

    // Arbiter to controller
    logic  reqAny;
    ifCfgT nextCfg;
    logic  nextRdWr;

    ifArbiter arb (
        .clk(clk), .reset(reset),
        .clearWei(clearWei), .clearAct(clearAct), .clearOfm(clearOfm), .cfgReq(cfgReq),
        .gbfFlgWeiEnWr(gbfFlgWeiEnWr), .gbfFlgWeiEnRd(gbfFlgWeiEnRd),
        .gbfWeiEnWr(gbfWeiEnWr), .gbfWeiEnRd(gbfWeiEnRd),
        .gbfFlgActEnWr(gbfFlgActEnWr), .gbfFlgActEnRd(gbfFlgActEnRd),
        .gbfActEnWr(gbfActEnWr), .gbfActEnRd(gbfActEnRd),
        .gbfFlgOfmEnWr(gbfFlgOfmEnWr), .gbfFlgOfmEnRd(gbfFlgOfmEnRd),
        .gbfOfmEnWr(gbfOfmEnWr), .gbfOfmEnRd(gbfOfmEnRd),
        .reqAny(reqAny), .nextCfg(nextCfg), .nextRdWr(nextRdWr)
    );

    burstController burst (
        .clk(clk), .reset(reset),
        .reqAny(reqAny), .nextCfg(nextCfg), .nextRdWr(nextRdWr),
        .ifRdy(ifRdy), .ifVal(ifVal),
        .ifReq(ifReq), .ifCfg(ifCfg), .ifRdWr(ifRdWr)
    );

endmodule

// File: hdl/ifArbiter.sv
// Fixed-priority choice among the six GBF buffers and the config request
// Output buffers always win since a full OFM stalls the array
// Purely combinational from the monitor registers

`timescale 1ns/1ps

`include "gbfIf_params.svh"

module ifArbiter
    import gbfIfPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clearWei,
    input  logic  clearAct,
    input  logic  clearOfm,
    input  logic  cfgReq,
    input  logic  gbfFlgWeiEnWr,
    input  logic  gbfFlgWeiEnRd,
    input  logic  gbfWeiEnWr,
    input  logic  gbfWeiEnRd,
    input  logic  gbfFlgActEnWr,
    input  logic  gbfFlgActEnRd,
    input  logic  gbfActEnWr,
    input  logic  gbfActEnRd,
    input  logic  gbfFlgOfmEnWr,
    input  logic  gbfFlgOfmEnRd,
    input  logic  gbfOfmEnWr,
    input  logic  gbfOfmEnRd,
    output logic  reqAny,
    output ifCfgT nextCfg,
    output logic  nextRdWr
);

    // ====================
    // Depths and watermarks
    // ====================
    localparam int FlgWeiDepth = 2 ** `GBF_FLGWEI_AW;
    localparam int WeiDepth    = 2 ** `GBF_WEI_AW;
    localparam int FlgActDepth = 2 ** `GBF_FLGACT_AW;
    localparam int ActDepth    = 2 ** `GBF_ACT_AW;
    localparam int FlgOfmDepth = 2 ** `GBF_FLGOFM_AW;
    localparam int OfmDepth    = 2 ** `GBF_OFM_AW;

    // Fill buffers use the low mark
    localparam int FlgWeiMark = FlgWeiDepth * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int WeiMark    = WeiDepth * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int FlgActMark = FlgActDepth * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int ActMark    = ActDepth * `GBF_LOW_NUM / `GBF_LOW_DEN;
    // Drain buffers use the high mark
    localparam int FlgOfmMark = FlgOfmDepth * `GBF_HIGH_NUM / `GBF_HIGH_DEN;
    localparam int OfmMark    = OfmDepth * `GBF_HIGH_NUM / `GBF_HIGH_DEN;

    // One request bit per buffer
    logic [NumBuf-1:0] bufReq;

    // ====================
    // Monitors
    // ====================
    bufferLevelMonitor #(.DEPTH(FlgWeiDepth), .WATERMARK(FlgWeiMark), .DRAIN(1'b0))
    flgWeiMon (
        .clk(clk), .reset(reset), .clear(clearWei),
        .enWr(gbfFlgWeiEnWr), .enRd(gbfFlgWeiEnRd), .serviceReq(bufReq[BufFlgWei])
    );

    bufferLevelMonitor #(.DEPTH(WeiDepth), .WATERMARK(WeiMark), .DRAIN(1'b0))
    weiMon (
        .clk(clk), .reset(reset), .clear(clearWei),
        .enWr(gbfWeiEnWr), .enRd(gbfWeiEnRd), .serviceReq(bufReq[BufWei])
    );

    bufferLevelMonitor #(.DEPTH(FlgActDepth), .WATERMARK(FlgActMark), .DRAIN(1'b0))
    flgActMon (
        .clk(clk), .reset(reset), .clear(clearAct),
        .enWr(gbfFlgActEnWr), .enRd(gbfFlgActEnRd), .serviceReq(bufReq[BufFlgAct])
    );

    bufferLevelMonitor #(.DEPTH(ActDepth), .WATERMARK(ActMark), .DRAIN(1'b0))
    actMon (
        .clk(clk), .reset(reset), .clear(clearAct),
        .enWr(gbfActEnWr), .enRd(gbfActEnRd), .serviceReq(bufReq[BufAct])
    );

    // Output side drains toward DRAM
    bufferLevelMonitor #(.DEPTH(FlgOfmDepth), .WATERMARK(FlgOfmMark), .DRAIN(1'b1))
    flgOfmMon (
        .clk(clk), .reset(reset), .clear(clearOfm),
        .enWr(gbfFlgOfmEnWr), .enRd(gbfFlgOfmEnRd), .serviceReq(bufReq[BufFlgOfm])
    );

    bufferLevelMonitor #(.DEPTH(OfmDepth), .WATERMARK(OfmMark), .DRAIN(1'b1))
    ofmMon (
        .clk(clk), .reset(reset), .clear(clearOfm),
        .enWr(gbfOfmEnWr), .enRd(gbfOfmEnRd), .serviceReq(bufReq[BufOfm])
    );

    // ====================
    // Priority select
    // ====================
    always_comb begin
        if (bufReq[BufFlgOfm]) begin
            nextCfg = FlgOfm;
        end else if (bufReq[BufOfm]) begin
            nextCfg = Ofm;
        end else if (cfgReq) begin
            nextCfg = Cfg;
        end else if (bufReq[BufFlgWei]) begin
            nextCfg = FlgWei;
        end else if (bufReq[BufWei]) begin
            nextCfg = Wei;
        end else if (bufReq[BufFlgAct]) begin
            nextCfg = FlgAct;
        end else if (bufReq[BufAct]) begin
            nextCfg = Act;
        end else begin
            nextCfg = Empty;
        end
    end

    // Only the output codes write to DRAM
    assign nextRdWr = !((nextCfg == FlgOfm) || (nextCfg == Ofm));
    assign reqAny   = cfgReq || (|bufReq);

endmodule

// File: tests/gbfInterfaceTb.sv
// Table rows must keep every occupancy inside 0..depth
// ifVal is held low while a row sets up, so bursts granted then are only drained
// Checked bursts stall on both ifRdy and ifVal at random

`timescale 1ns/1ps

`include "gbfIf_params.svh"

module gbfInterfaceTb
    import gbfIfPkg::*;
();

    localparam int MaxRows  = 16;
    localparam int BurstLen = `IF_BURST_LEN;

    // Watermarks from the shared sizes
    localparam int FlgWeiLow  = (2 ** `GBF_FLGWEI_AW) * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int WeiLow     = (2 ** `GBF_WEI_AW) * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int FlgActLow  = (2 ** `GBF_FLGACT_AW) * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int ActLow     = (2 ** `GBF_ACT_AW) * `GBF_LOW_NUM / `GBF_LOW_DEN;
    localparam int FlgOfmHigh = (2 ** `GBF_FLGOFM_AW) * `GBF_HIGH_NUM / `GBF_HIGH_DEN;
    localparam int OfmHigh    = (2 ** `GBF_OFM_AW) * `GBF_HIGH_NUM / `GBF_HIGH_DEN;

    logic  clk;
    logic  reset;
    logic  clearWei;
    logic  clearAct;
    logic  clearOfm;
    logic  cfgReq;
    logic  gbfFlgWeiEnWr;
    logic  gbfFlgWeiEnRd;
    logic  gbfWeiEnWr;
    logic  gbfWeiEnRd;
    logic  gbfFlgActEnWr;
    logic  gbfFlgActEnRd;
    logic  gbfActEnWr;
    logic  gbfActEnRd;
    logic  gbfFlgOfmEnWr;
    logic  gbfFlgOfmEnRd;
    logic  gbfOfmEnWr;
    logic  gbfOfmEnRd;
    logic  ifRdy;
    logic  ifVal;
    logic  ifReq;
    ifCfgT ifCfg;
    logic  ifRdWr;

    // Stimulus table with one entry per row
    int         wrCnt[MaxRows][NumBuf];
    int         rdCnt[MaxRows][NumBuf];
    logic [2:0] clrTab[MaxRows];
    logic       cfgTab[MaxRows];
    logic       cfgMidTab[MaxRows];
    ifCfgT      expCfgTab[MaxRows];
    logic       expRdWrTab[MaxRows];
    int         numRows;
    int         maxCount;

    // Occupancy model per buffer
    int occ[NumBuf];
    int seed;
    int cycleCnt;
    int cycleLimit;
    int r;
    ifCfgT expCfg;

    gbfInterface uut (.*);

    always #10 clk = ~clk;

    // ====================
    // Timeout
    // ====================
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt > cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkIfCfg(input string name, input ifCfgT got, input ifCfgT exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ====================
    // Table
    // ====================
    // clr bits are Wei, Act, Ofm from bit 0
    task automatic addRow(input logic cfg, input logic cfgMid, input logic [2:0] clr,
                          input ifCfgT exp, input logic expRdWr);
        int b;
        for (b = 0; b < NumBuf; b++) begin
            wrCnt[numRows][b] = 0;
            rdCnt[numRows][b] = 0;
        end
        cfgTab[numRows]     = cfg;
        cfgMidTab[numRows]  = cfgMid;
        clrTab[numRows]     = clr;
        expCfgTab[numRows]  = exp;
        expRdWrTab[numRows] = expRdWr;
        numRows++;
    endtask

    // Counts go to the row added last
    task automatic setCount(input bufIdxT b, input int wr, input int rd);
        wrCnt[numRows-1][b] = wr;
        rdCnt[numRows-1][b] = rd;
        if (wr > maxCount) maxCount = wr;
        if (rd > maxCount) maxCount = rd;
    endtask

    task automatic buildTable();
        addRow(1'b0, 1'b0, 3'b000, FlgWei, 1'b1);
        addRow(1'b1, 1'b0, 3'b000, Cfg, 1'b1);
        addRow(1'b0, 1'b0, 3'b000, Wei, 1'b1);
        setCount(BufFlgWei, 5, 0);
        addRow(1'b0, 1'b0, 3'b000, FlgAct, 1'b1);
        setCount(BufWei, 17, 0);
        addRow(1'b0, 1'b0, 3'b000, Act, 1'b1);
        setCount(BufFlgAct, 5, 0);
        // Drain side
        addRow(1'b0, 1'b0, 3'b000, Ofm, 1'b0);
        setCount(BufOfm, 49, 0);
        addRow(1'b0, 1'b0, 3'b000, FlgOfm, 1'b0);
        setCount(BufFlgOfm, 13, 0);
        addRow(1'b0, 1'b0, 3'b100, Act, 1'b1);
        // Config request shows up mid burst
        addRow(1'b0, 1'b1, 3'b000, Act, 1'b1);
        // Overlapping enables and then nothing left to serve
        addRow(1'b0, 1'b0, 3'b000, Empty, 1'b1);
        setCount(BufAct, 20, 3);
        addRow(1'b0, 1'b0, 3'b000, Wei, 1'b1);
        setCount(BufFlgWei, 2, 2);
        setCount(BufWei, 0, 1);
        addRow(1'b0, 1'b0, 3'b001, FlgWei, 1'b1);
    endtask

    // ====================
    // Model
    // ====================
    function automatic ifCfgT predictCfg(input logic cfgLevel);
        if (occ[BufFlgOfm] > FlgOfmHigh) return FlgOfm;
        if (occ[BufOfm] > OfmHigh) return Ofm;
        if (cfgLevel) return Cfg;
        if (occ[BufFlgWei] <= FlgWeiLow) return FlgWei;
        if (occ[BufWei] <= WeiLow) return Wei;
        if (occ[BufFlgAct] <= FlgActLow) return FlgAct;
        if (occ[BufAct] <= ActLow) return Act;
        return Empty;
    endfunction

    // Output codes write to DRAM
    function automatic logic predictRdWr(input ifCfgT code);
        case (code)
            FlgOfm, Ofm: return 1'b0;
            default:     return 1'b1;
        endcase
    endfunction

    task automatic driveEnables(input logic [5:0] wr, input logic [5:0] rd);
        gbfFlgWeiEnWr = wr[BufFlgWei];
        gbfFlgWeiEnRd = rd[BufFlgWei];
        gbfWeiEnWr    = wr[BufWei];
        gbfWeiEnRd    = rd[BufWei];
        gbfFlgActEnWr = wr[BufFlgAct];
        gbfFlgActEnRd = rd[BufFlgAct];
        gbfActEnWr    = wr[BufAct];
        gbfActEnRd    = rd[BufAct];
        gbfFlgOfmEnWr = wr[BufFlgOfm];
        gbfFlgOfmEnRd = rd[BufFlgOfm];
        gbfOfmEnWr    = wr[BufOfm];
        gbfOfmEnRd    = rd[BufOfm];
    endtask

    // ====================
    // Row phases
    // ====================
    // Link stalled while the buffers move
    task automatic applyRow(input int row);
        int n;
        int i;
        int b;
        logic [5:0] wr;
        logic [5:0] rd;
        ifVal  = 1'b0;
        ifRdy  = 1'b0;
        cfgReq = cfgTab[row];
        if (clrTab[row] != 3'b000) begin
            clearWei = clrTab[row][0];
            clearAct = clrTab[row][1];
            clearOfm = clrTab[row][2];
            @(negedge clk);
            clearWei = 1'b0;
            clearAct = 1'b0;
            clearOfm = 1'b0;
            if (clrTab[row][0]) begin
                occ[BufFlgWei] = 0;
                occ[BufWei]    = 0;
            end
            if (clrTab[row][1]) begin
                occ[BufFlgAct] = 0;
                occ[BufAct]    = 0;
            end
            if (clrTab[row][2]) begin
                occ[BufFlgOfm] = 0;
                occ[BufOfm]    = 0;
            end
        end
        n = 0;
        for (b = 0; b < NumBuf; b++) begin
            if (wrCnt[row][b] > n) n = wrCnt[row][b];
            if (rdCnt[row][b] > n) n = rdCnt[row][b];
        end
        // One enable per cycle and both at once leave the level
        for (i = 0; i < n; i++) begin
            for (b = 0; b < NumBuf; b++) begin
                wr[b] = (i < wrCnt[row][b]);
                rd[b] = (i < rdCnt[row][b]);
                if (wr[b] && !rd[b]) occ[b]++;
                else if (rd[b] && !wr[b]) occ[b]--;
            end
            driveEnables(wr, rd);
            @(negedge clk);
        end
        driveEnables(6'b0, 6'b0);
    endtask

    // Finish whatever burst was granted during setup
    task automatic drainStale();
        int rnd;
        ifVal = 1'b1;
        while (ifReq) begin
            rnd   = $random(seed);
            ifRdy = rnd[0];
            @(negedge clk);
        end
    endtask

    task automatic checkBurst(input ifCfgT exp, input logic expRdWr, input logic cfgMid);
        int waitCnt;
        int beats;
        int rnd;
        waitCnt = 0;
        while (!ifReq) begin
            if (waitCnt == 4) begin
                abortRun($sformatf("No ifReq within 4 cycles for code 0x%h", exp));
            end
            @(negedge clk);
            waitCnt++;
        end
        checkIfCfg("ifCfg", ifCfg, exp);
        checkBit("ifRdWr", ifRdWr, expRdWr);
        beats = 0;
        while (beats < BurstLen) begin
            rnd   = $random(seed);
            ifRdy = rnd[0];
            ifVal = rnd[1];
            // Higher request must not switch the burst
            if (cfgMid && beats == 1) cfgReq = 1'b1;
            if (ifRdy && ifVal) beats++;
            @(negedge clk);
            if (beats < BurstLen) begin
                checkBit("ifReq", ifReq, 1'b1);
                checkIfCfg("ifCfg", ifCfg, exp);
                checkBit("ifRdWr", ifRdWr, expRdWr);
            end
        end
        // Falls one cycle after the last beat
        checkBit("ifReq", ifReq, 1'b0);
        ifRdy = 1'b0;
    endtask

    task automatic checkIdle();
        int i;
        for (i = 0; i < 4; i++) begin
            checkBit("ifReq", ifReq, 1'b0);
            checkIfCfg("ifCfg", ifCfg, Empty);
            checkBit("ifRdWr", ifRdWr, 1'b1);
            @(negedge clk);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        clearWei = 1'b0;
        clearAct = 1'b0;
        clearOfm = 1'b0;
        cfgReq   = 1'b0;
        ifRdy    = 1'b0;
        ifVal    = 1'b0;
        driveEnables(6'b0, 6'b0);
        seed     = 68696;
        cycleCnt = 0;
        numRows  = 0;
        maxCount = 0;
        for (r = 0; r < NumBuf; r++) occ[r] = 0;
        buildTable();
        cycleLimit = numRows * (maxCount + BurstLen * 8 + 10);

        repeat (5) @(negedge clk);
        reset = 1'b0;
        checkBit("ifReq", ifReq, 1'b0);
        checkIfCfg("ifCfg", ifCfg, Empty);
        checkBit("ifRdWr", ifRdWr, 1'b1);
        // Fill buffers all low so the grant comes one cycle later
        @(negedge clk);
        checkBit("ifReq", ifReq, 1'b1);
        checkIfCfg("ifCfg", ifCfg, FlgWei);
        checkBit("ifRdWr", ifRdWr, 1'b1);

        for (r = 0; r < numRows; r++) begin
            applyRow(r);
            drainStale();
            expCfg = predictCfg(cfgTab[r]);
            if (expCfg !== expCfgTab[r] || predictRdWr(expCfg) !== expRdWrTab[r]) begin
                abortRun($sformatf("Table row %0d does not match the occupancy model", r));
            end
            if (expCfg == Empty) checkIdle();
            else checkBurst(expCfg, predictRdWr(expCfg), cfgMidTab[r]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
